//--- Makefile
TOP := tb_opn

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- common/opn_pkg.sv
// shared register map, divider encodings and timer widths for the OPN timing core
package opn_pkg;

    // divider selector, same encoding as the chip's internal prescaler latch
    typedef logic [1:0] div_setting_t;

    localparam div_setting_t DIV_RESET = 2'b10;  // FM 1/6, SSG 1/4

    // prescaler commands, the data byte is don't care
    localparam logic [7:0] ADDR_PRES_2D = 8'h2D;  // sets bit 1
    localparam logic [7:0] ADDR_PRES_2E = 8'h2E;  // sets bit 0
    localparam logic [7:0] ADDR_PRES_2F = 8'h2F;  // clears both

    // timer registers
    localparam logic [7:0] ADDR_TA_HI  = 8'h24;  // timer A bits 9:2
    localparam logic [7:0] ADDR_TA_LO  = 8'h25;  // timer A bits 1:0
    localparam logic [7:0] ADDR_TB     = 8'h26;
    localparam logic [7:0] ADDR_TCTRL  = 8'h27;

    // bit positions inside register 0x27
    localparam logic [2:0] CTRL_LOAD_A = 3'd0;  // run timer A
    localparam logic [2:0] CTRL_LOAD_B = 3'd1;  // run timer B
    localparam logic [2:0] CTRL_EN_A   = 3'd2;  // let A overflow set its flag
    localparam logic [2:0] CTRL_EN_B   = 3'd3;
    localparam logic [2:0] CTRL_RST_A  = 3'd4;  // clear flag A, self clearing
    localparam logic [2:0] CTRL_RST_B  = 3'd5;

    // timer geometry
    localparam int TA_W   = 10;
    localparam int TB_W   = 8;
    localparam int TB_PRE = 16;  // FM enables per timer B tick

endpackage

//--- files.f
common/opn_pkg.sv
hw/prescaler/opn_prescaler.sv
hw/opn_write_queue.sv
hw/opn_regs.sv
hw/timers/opn_timers.sv
hw/opn_top.sv
verif/tb_opn.sv

//--- hw/opn_regs.sv
// register decoder, turns drained writes into divider and timer control state
`timescale 1ns/1ps
module opn_regs
    import opn_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            clk_en,
    input  logic            pop_valid,
    input  logic [7:0]      pop_addr,
    input  logic [7:0]      pop_data,
    output div_setting_t    div_setting,
    output logic [TA_W-1:0] ta_value,
    output logic [TB_W-1:0] tb_value,
    output logic            ctrl_load_a,
    output logic            ctrl_load_b,
    output logic            ctrl_en_a,
    output logic            ctrl_en_b,
    output logic            clr_a,        // one cycle pulse
    output logic            clr_b
);

    logic       apply;  // same condition the queue pops on
    logic [7:0] ta_hi;
    logic [1:0] ta_lo;

    assign apply    = clk_en & pop_valid;
    assign ta_value = {ta_hi, ta_lo};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_setting <= DIV_RESET;
            ta_hi       <= '0;
            ta_lo       <= '0;
            tb_value    <= '0;
            ctrl_load_a <= 1'b0;
            ctrl_load_b <= 1'b0;
            ctrl_en_a   <= 1'b0;
            ctrl_en_b   <= 1'b0;
            clr_a       <= 1'b0;
            clr_b       <= 1'b0;
        end else begin
            clr_a <= 1'b0;  // pulses drop unless rewritten
            clr_b <= 1'b0;
            if (apply) begin
                case (pop_addr)
                    ADDR_PRES_2D: div_setting[1] <= 1'b1;
                    ADDR_PRES_2E: div_setting[0] <= 1'b1;
                    ADDR_PRES_2F: div_setting    <= 2'b00;
                    ADDR_TA_HI:   ta_hi          <= pop_data;
                    ADDR_TA_LO:   ta_lo          <= pop_data[1:0];
                    ADDR_TB:      tb_value       <= pop_data;
                    ADDR_TCTRL: begin
                        ctrl_load_a <= pop_data[CTRL_LOAD_A];
                        ctrl_load_b <= pop_data[CTRL_LOAD_B];
                        ctrl_en_a   <= pop_data[CTRL_EN_A];
                        ctrl_en_b   <= pop_data[CTRL_EN_B];
                        clr_a       <= pop_data[CTRL_RST_A];
                        clr_b       <= pop_data[CTRL_RST_B];
                    end
                    default: ;  // unmapped, dropped
                endcase
            end
        end
    end

endmodule

//--- hw/opn_top.sv
// timing core top, write queue to decoder to prescaler and timers
`timescale 1ns/1ps
module opn_top
    import opn_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int USE_SSG     = 1
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,
    input  logic       wr_valid,
    input  logic [7:0] wr_addr,
    input  logic [7:0] wr_data,
    output logic       credit_return,
    output logic       clk_en,
    output logic       clk_en_2,
    output logic       clk_en_ssg,
    output logic       clk_en_666,
    output logic       clk_en_111,
    output logic       clk_en_55,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    logic            pop_valid;
    logic [7:0]      pop_addr;
    logic [7:0]      pop_data;
    div_setting_t    div_setting;
    logic [TA_W-1:0] ta_value;
    logic [TB_W-1:0] tb_value;
    logic            ctrl_load_a;
    logic            ctrl_load_b;
    logic            ctrl_en_a;
    logic            ctrl_en_b;
    logic            clr_a;
    logic            clr_b;

    opn_write_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk(clk), .arst_n(arst_n),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
        .clk_en(clk_en),  // drains at the FM write rate
        .pop_valid(pop_valid), .pop_addr(pop_addr), .pop_data(pop_data),
        .credit_return(credit_return)
    );

    opn_regs i_regs (
        .clk(clk), .arst_n(arst_n), .clk_en(clk_en),
        .pop_valid(pop_valid), .pop_addr(pop_addr), .pop_data(pop_data),
        .div_setting(div_setting), .ta_value(ta_value), .tb_value(tb_value),
        .ctrl_load_a(ctrl_load_a), .ctrl_load_b(ctrl_load_b),
        .ctrl_en_a(ctrl_en_a), .ctrl_en_b(ctrl_en_b),
        .clr_a(clr_a), .clr_b(clr_b)
    );

    opn_prescaler #(.USE_SSG(USE_SSG)) i_prescaler (
        .clk(clk), .arst_n(arst_n), .cen(cen), .div_setting(div_setting),
        .clk_en(clk_en), .clk_en_2(clk_en_2), .clk_en_ssg(clk_en_ssg),
        .clk_en_666(clk_en_666), .clk_en_111(clk_en_111), .clk_en_55(clk_en_55)
    );

    opn_timers i_timers (
        .clk(clk), .arst_n(arst_n), .clk_en(clk_en),
        .ta_value(ta_value), .tb_value(tb_value),
        .ctrl_load_a(ctrl_load_a), .ctrl_load_b(ctrl_load_b),
        .ctrl_en_a(ctrl_en_a), .ctrl_en_b(ctrl_en_b),
        .clr_a(clr_a), .clr_b(clr_b),
        .flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
    );

endmodule

//--- hw/opn_write_queue.sv
// host register write FIFO, one entry drained per FM enable, one credit back per drain
`timescale 1ns/1ps
module opn_write_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_valid,     // host only drives this while holding a credit
    input  logic [7:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic       clk_en,
    output logic       pop_valid,
    output logic [7:0] pop_addr,
    output logic [7:0] pop_data,
    output logic       credit_return
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL = (PTR_W + 1)'(QUEUE_DEPTH);

    logic [7:0]       mem_addr [QUEUE_DEPTH];
    logic [7:0]       mem_data [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;   // power of two depth, pointers wrap on their own
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign pop_valid = (count != '0);
    assign pop       = clk_en & pop_valid;  // decoder consumes on the same edge
    assign pop_addr  = mem_addr[rd_ptr];
    assign pop_data  = mem_data[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem_addr[wr_ptr] <= wr_addr;
            mem_data[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (wr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count         <= count + (wr_valid ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
            credit_return <= pop;  // cycle after the pop
        end
    end

    // host broke the credit protocol
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        wr_valid |-> (count != FULL));

    a_occupancy: assert property (@(posedge clk) disable iff (!arst_n)
        count <= FULL);

endmodule

//--- hw/prescaler/opn_prescaler.sv
// clock enable generator, divides the master cen into FM, SSG and ADPCM rates
`timescale 1ns/1ps
module opn_prescaler
    import opn_pkg::*;
#(
    parameter int USE_SSG = 1
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         cen,
    input  div_setting_t div_setting,
    output logic         clk_en,      // FM rate
    output logic         clk_en_2,    // cen / 3, fixed
    output logic         clk_en_ssg,
    output logic         clk_en_666,  // cen / 12
    output logic         clk_en_111,  // cen / 72
    output logic         clk_en_55    // cen / 144
);

    logic [2:0] fm_cnt;
    logic [2:0] fm_top;    // terminal count in use, ratio - 1
    logic [1:0] ssg_cnt;
    logic [1:0] ssg_top;
    logic [1:0] div3_cnt;
    logic [3:0] cnt_666;   // 0..11
    logic [2:0] cnt_111;   // 0..5, steps on each 666 wrap
    logic       cnt_55;    // 0..1, steps on each 111 wrap

    // FM ratio - 1 for a divider setting
    function automatic logic [2:0] fm_ratio(input div_setting_t sel);
        case (sel)
            2'b10:   return 3'd5;  // 1/6
            2'b11:   return 3'd2;  // 1/3
            default: return 3'd1;  // 1/2
        endcase
    endfunction

    // SSG ratio - 1 for a divider setting
    function automatic logic [1:0] ssg_ratio(input div_setting_t sel);
        case (sel)
            2'b10:   return 2'd3;  // 1/4
            2'b11:   return 2'd1;  // 1/2
            default: return 2'd0;  // every cen
        endcase
    endfunction

    // wrap counters, all frozen while cen is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fm_cnt   <= '0;
            fm_top   <= fm_ratio(DIV_RESET);
            ssg_cnt  <= '0;
            ssg_top  <= ssg_ratio(DIV_RESET);
            div3_cnt <= '0;
            cnt_666  <= '0;
            cnt_111  <= '0;
            cnt_55   <= 1'b0;
        end else if (cen) begin
            if (fm_cnt == fm_top) begin
                fm_cnt <= '0;
                fm_top <= fm_ratio(div_setting);  // new ratio only at a wrap
            end else begin
                fm_cnt <= fm_cnt + 3'd1;
            end
            if (ssg_cnt == ssg_top) begin
                ssg_cnt <= '0;
                ssg_top <= ssg_ratio(div_setting);
            end else begin
                ssg_cnt <= ssg_cnt + 2'd1;
            end
            div3_cnt <= (div3_cnt == 2'd2) ? 2'd0 : div3_cnt + 2'd1;
            cnt_666  <= (cnt_666 == 4'd11) ? 4'd0 : cnt_666 + 4'd1;
            if (cnt_666 == 4'd0) begin
                cnt_111 <= (cnt_111 == 3'd5) ? 3'd0 : cnt_111 + 3'd1;
                if (cnt_111 == 3'd0)
                    cnt_55 <= ~cnt_55;  // two states only
            end
        end
    end

    // registered enables, one cycle wide, only on a cen cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_en     <= 1'b0;
            clk_en_2   <= 1'b0;
            clk_en_ssg <= 1'b0;
            clk_en_666 <= 1'b0;
            clk_en_111 <= 1'b0;
            clk_en_55  <= 1'b0;
        end else begin
            clk_en     <= cen & (fm_cnt == '0);
            clk_en_2   <= cen & (div3_cnt == '0);
            clk_en_ssg <= (USE_SSG != 0) & cen & (ssg_cnt == '0);  // tied low without SSG
            clk_en_666 <= cen & (cnt_666 == '0);
            clk_en_111 <= cen & (cnt_666 == '0) & (cnt_111 == '0);
            clk_en_55  <= cen & (cnt_666 == '0) & (cnt_111 == '0) & ~cnt_55;
        end
    end

    // ADPCM rates must stay nested
    a_adpcm_nested: assert property (@(posedge clk) disable iff (!arst_n)
        (clk_en_55 |-> clk_en_111) and (clk_en_111 |-> clk_en_666));

endmodule

//--- hw/timers/opn_timers.sv
// timer A and timer B with sticky overflow flags and an active low interrupt
`timescale 1ns/1ps
module opn_timers
    import opn_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            clk_en,
    input  logic [TA_W-1:0] ta_value,
    input  logic [TB_W-1:0] tb_value,
    input  logic            ctrl_load_a,
    input  logic            ctrl_load_b,
    input  logic            ctrl_en_a,
    input  logic            ctrl_en_b,
    input  logic            clr_a,
    input  logic            clr_b,
    output logic            flag_a,
    output logic            flag_b,
    output logic            irq_n
);

    localparam int PRE_W = $clog2(TB_PRE);

    logic [TA_W-1:0]  cnt_a;
    logic [TB_W-1:0]  cnt_b;
    logic [PRE_W-1:0] pre_b;   // timer B prescale
    logic             tick_b;
    logic             ovf_a;
    logic             ovf_b;
    logic             flag_a_nxt;
    logic             flag_b_nxt;

    assign tick_b = clk_en & ctrl_load_b & (pre_b == PRE_W'(TB_PRE - 1));
    assign ovf_a  = clk_en & ctrl_load_a & (cnt_a == '1);  // 1023 rolls over
    assign ovf_b  = tick_b & (cnt_b == '1);

    // set beats clear when both land together
    assign flag_a_nxt = (flag_a & ~clr_a) | (ovf_a & ctrl_en_a);
    assign flag_b_nxt = (flag_b & ~clr_b) | (ovf_b & ctrl_en_b);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_a <= '0;
            cnt_b <= '0;
            pre_b <= '0;
        end else begin
            if (!ctrl_load_a)
                cnt_a <= ta_value;        // stopped timer holds its start value
            else if (ovf_a)
                cnt_a <= ta_value;        // reload
            else if (clk_en)
                cnt_a <= cnt_a + 1'b1;

            if (!ctrl_load_b) begin
                cnt_b <= tb_value;
                pre_b <= '0;              // full 16 enables before first tick
            end else if (clk_en) begin
                pre_b <= pre_b + 1'b1;
                if (ovf_b)
                    cnt_b <= tb_value;
                else if (tick_b)
                    cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // flags and irq from the same next state, so irq_n lines up with the flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            flag_a <= flag_a_nxt;
            flag_b <= flag_b_nxt;
            irq_n  <= ~(flag_a_nxt | flag_b_nxt);
        end
    end

    // a flag only comes up on its own timer's overflow
    a_flag_src: assert property (@(posedge clk) disable iff (!arst_n)
        ($rose(flag_a) |-> $past(ovf_a)) and ($rose(flag_b) |-> $past(ovf_b)));

endmodule

//--- verif/tb_opn.sv
// testbench for opn_top that drives host writes and cen and checks periods, credits and timers
`timescale 1ns/1ps
module tb_opn
    import opn_pkg::*;
();

    localparam int DEPTH = 4;
    localparam int LIMIT = 20000;  // cycles any single wait may take

    logic clk, arst_n, cen, wr_valid;
    logic [7:0] wr_addr, wr_data;
    logic credit_return, clk_en, clk_en_2, clk_en_ssg, clk_en_666, clk_en_111, clk_en_55;
    logic flag_a, flag_b, irq_n;

    int     credits = DEPTH;  // host side credit model
    int     returns = 0;
    int     en_count = 0;     // FM enables seen so far
    int     last_ret = 0;     // en_count at the latest credit return
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    integer seed = 32'hea6c;

    opn_top #(.QUEUE_DEPTH(DEPTH), .USE_SSG(1)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (clk_en)
            en_count++;
        if (credit_return) begin
            credits++;
            returns++;
            last_ret = en_count;
        end
    end

    // no more credits come back than the queue holds
    a_credit_range: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= DEPTH)
        else begin
            errors++;
            $display("more credits returned than the queue holds: %0d", credits);
        end
    a_irq_match: assert property (@(posedge clk) disable iff (!arst_n)
        irq_n == !(flag_a || flag_b))
        else begin
            errors++;
            $display("irq_n does not follow the flags");
        end
    a_nested: assert property (@(posedge clk) disable iff (!arst_n)
        (clk_en_55 |-> clk_en_111) and (clk_en_111 |-> clk_en_666))
        else begin
            errors++;
            $display("ADPCM enables are not nested");
        end
    a_cen_gate: assert property (@(posedge clk) disable iff (!arst_n)
        clk_en |-> $past(cen))
        else begin
            errors++;
            $display("FM enable without cen");
        end

    function automatic logic en_sel(input int sel);
        case (sel)
            0: return clk_en;
            1: return clk_en_2;
            2: return clk_en_ssg;
            3: return clk_en_666;
            4: return clk_en_111;
            default: return clk_en_55;
        endcase
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act)
        else begin
            errors++;
            $display("error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // negedges until the next pulse of one enable
    task automatic wait_pulse(input int sel, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!en_sel(sel) && cycles < LIMIT);
        if (!en_sel(sel)) begin
            errors++;
            $display("timed out waiting for enable %0d", sel);
        end
    endtask

    // first interval may straddle a divider change and is skipped
    task automatic check_period(input string name, input int sel, input int exp);
        int c;
        wait_pulse(sel, c);
        wait_pulse(sel, c);
        wait_pulse(sel, c);
        check_value(name, exp, c);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        int t;
        t = 0;
        while (credits == 0 && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (credits == 0) begin
            errors++;
            $display("timed out waiting for a write credit");
        end else begin
            wr_valid = 1'b1;
            wr_addr  = addr;
            wr_data  = data;
            credits--;
            @(negedge clk);
            wr_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (credits != DEPTH && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (credits != DEPTH) begin
            errors++;
            $display("queue did not drain, %0d credits held", credits);
        end
    endtask

    // wait for a flag and count FM enables since the latest credit return
    task automatic wait_flag(input int which, output int ticks);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!(which == 0 ? flag_a : flag_b) && t < LIMIT);
        if (!(which == 0 ? flag_a : flag_b)) begin
            errors++;
            $display("timed out waiting for timer flag %0d", which);
        end
        ticks = en_count - last_ret;
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start)
            tests_failed++;
        $display("test %s: %s", name, (errors == err_start) ? "ok" : "failed");
    endtask

    initial begin
        int e, n, m, ticks, c, base;
        cen = 1'b1;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        arst_n = 1'b0;
        repeat (10) @(negedge clk);

        e = errors;  // reset state and reset periods
        check_value("reset enables", 0,
                    {clk_en, clk_en_2, clk_en_ssg, clk_en_666, clk_en_111, clk_en_55});
        check_value("reset irq_n", 1, irq_n);
        check_value("reset credit_return", 0, credit_return);
        arst_n = 1'b1;
        check_period("fm reset", 0, 6);
        check_period("div2", 1, 3);
        check_period("ssg reset", 2, 4);
        check_period("666", 3, 12);
        check_period("111", 4, 72);
        check_period("55", 5, 144);
        end_test("reset", e);

        e = errors;
        write_reg(ADDR_PRES_2F, 8'h00);
        wait_drained();
        check_period("fm 2f", 0, 2);
        check_period("ssg 2f", 2, 1);
        write_reg(ADDR_PRES_2D, 8'h00);
        wait_drained();
        check_period("fm 2d", 0, 6);
        check_period("ssg 2d", 2, 4);
        write_reg(ADDR_PRES_2E, 8'h00);
        wait_drained();
        check_period("fm 2e", 0, 3);
        check_period("ssg 2e", 2, 2);
        end_test("prescaler", e);

        e = errors;  // unmapped address so only credits matter
        base = returns;
        for (int i = 0; i < 10; i++)
            write_reg(8'h30, 8'(i));
        wait_drained();
        check_value("credit returns", 10, returns - base);
        end_test("credits", e);

        e = errors;
        n = $random(seed) & 10'h3ff;
        write_reg(ADDR_TA_HI, 8'(n >> 2));
        write_reg(ADDR_TA_LO, 8'(n & 3));
        write_reg(ADDR_TCTRL, 8'h05);  // run A with flag A enabled
        wait_flag(0, ticks);
        check_value("timer a ticks", 1024 - n, ticks);
        check_value("timer a irq_n", 0, irq_n);
        write_reg(ADDR_TCTRL, 8'h10);  // stop and clear A
        wait_drained();
        repeat (2) @(negedge clk);
        check_value("timer a cleared irq_n", 1, irq_n);
        end_test("timer_a", e);

        e = errors;
        m = $random(seed) & 8'hff;
        write_reg(ADDR_TB, 8'(m));
        write_reg(ADDR_TCTRL, 8'h02);  // run B with flag B disabled
        wait_drained();
        base = en_count;
        c = 0;
        while (en_count - base < 16 * (256 - m) + 32 && c < 4 * LIMIT) begin
            @(negedge clk);
            c++;
            if (flag_b)
                c = 4 * LIMIT;
        end
        if (!flag_b && en_count - base < 16 * (256 - m) + 32) begin
            errors++;
            $display("timed out waiting for timer b to pass its overflow");
        end
        check_value("timer b disabled flag", 0, flag_b);
        write_reg(ADDR_TCTRL, 8'h00);
        write_reg(ADDR_TCTRL, 8'h0a);  // run B with flag B enabled
        wait_flag(1, ticks);
        check_value("timer b ticks", 16 * (256 - m), ticks);
        write_reg(ADDR_TCTRL, 8'h20);  // stop and clear B
        wait_drained();
        check_value("timer b cleared flag", 0, flag_b);
        end_test("timer_b", e);

        e = errors;
        cen = 1'b0;
        repeat (2) @(negedge clk);
        write_reg(ADDR_PRES_2F, 8'h00);
        c = 0;
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
            c += clk_en + clk_en_2 + clk_en_ssg + clk_en_666;
            c += clk_en_111 + clk_en_55 + credit_return;
        end
        check_value("pulses with cen low", 0, c);
        check_value("credits with cen low", DEPTH - 1, credits);
        cen = 1'b1;
        wait_drained();
        check_period("fm after cen", 0, 2);
        end_test("cen_hold", e);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
